/* common/i2si_pkg.sv */
`default_nettype none

package i2si_pkg;

    ////////////////////////////////////////
    // Data types
    ////////////////////////////////////////

    typedef logic [15:0] sample_t;          // One channel word, MSB first on the wire

    typedef struct packed {
        sample_t lft;                       // Word received while ws was low
        sample_t rgt;                       // Word received while ws was high
    } i2s_frame_t;

    typedef logic [1:0]  wb_addr_t;         // Word address into the register map
    typedef logic [31:0] wb_data_t;         // Wishbone data bus
    typedef logic [2:0]  fifo_level_t;      // Holds 0 up to FIFO_DEPTH

    localparam int unsigned FIFO_DEPTH = 4; // Stereo frames held in the FIFO

    ////////////////////////////////////////
    // Register map
    ////////////////////////////////////////

    localparam wb_addr_t ADDR_CTRL   = 2'd0; // Bit 0 enable, bit 1 write 1 clears overrun
    localparam wb_addr_t ADDR_STATUS = 2'd1; // Level, empty, full and overrun
    localparam wb_addr_t ADDR_LEFT   = 2'd2; // Head frame left word
    localparam wb_addr_t ADDR_RIGHT  = 2'd3; // Head frame right word, read pops

    // Receiver sequence
    typedef enum logic [1:0] {
        RX_IDLE   = 2'd0,                   // Disabled, nothing captured
        RX_ARMED  = 2'd1,                   // Waiting for the first ws fall
        RX_ACTIVE = 2'd2                    // Every ws fall completes a frame
    } rx_state_t;

endpackage

`default_nettype wire

/* hw/i2si_top.sv */
`default_nettype none

module i2si_top
(
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      sck,       // I2S bit clock, slave mode
    input  wire                      ws,
    input  wire                      sd,
    input  wire                      wb_cyc,
    input  wire                      wb_stb,
    input  wire                      wb_we,
    input  wire  i2si_pkg::wb_addr_t wb_adr,
    input  wire  i2si_pkg::wb_data_t wb_dat_w,
    output i2si_pkg::wb_data_t       wb_dat_r,
    output logic                     wb_ack
);

    import i2si_pkg::*;

    i2s_frame_t  frame;                     // Deserializer to FIFO
    logic        xfc;
    i2s_frame_t  head;                      // FIFO head to register block
    fifo_level_t level;
    logic        empty;
    logic        full;
    logic        drop;
    logic        enable;
    logic        pop;

    ////////////////////////////////////////
    // Receive path
    ////////////////////////////////////////

    i2si_deserializer u_deserializer (
        .clk    (clk),
        .rst_n  (rst_n),
        .sck    (sck),
        .ws     (ws),
        .sd     (sd),
        .enable (enable),
        .frame  (frame),
        .xfc    (xfc)
    );

    i2si_frame_fifo #(.DEPTH(FIFO_DEPTH)) u_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (xfc),                       // Each completed frame is offered once
        .din   (frame),
        .pop   (pop),
        .head  (head),
        .level (level),
        .empty (empty),
        .full  (full),
        .drop  (drop)
    );

    i2si_wb_regs u_regs (
        .clk    (clk),
        .rst_n  (rst_n),
        .cyc    (wb_cyc),
        .stb    (wb_stb),
        .we     (wb_we),
        .adr    (wb_adr),
        .dat_w  (wb_dat_w),
        .dat_r  (wb_dat_r),
        .ack    (wb_ack),
        .enable (enable),
        .pop    (pop),
        .head   (head),
        .level  (level),
        .empty  (empty),
        .full   (full),
        .drop   (drop)
    );

endmodule

`default_nettype wire

/* hw/i2si_wb_regs.sv */
`default_nettype none

module i2si_wb_regs
(
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         cyc,
    input  wire                         stb,
    input  wire                         we,
    input  wire  i2si_pkg::wb_addr_t    adr,
    input  wire  i2si_pkg::wb_data_t    dat_w,
    output i2si_pkg::wb_data_t          dat_r,  // Valid while ack is high
    output logic                        ack,
    output logic                        enable, // CTRL bit 0
    output logic                        pop,    // High on the ack of a RIGHT read
    input  wire  i2si_pkg::i2s_frame_t  head,
    input  wire  i2si_pkg::fifo_level_t level,
    input  wire                         empty,
    input  wire                         full,
    input  wire                         drop
);

    import i2si_pkg::*;

    logic     req;                          // New access seen this cycle
    logic     ctrl_wr;
    logic     rd_right;
    logic     overrun;                      // Sticky, set by a dropped frame
    wb_data_t rd_val;

    // ack blocks req for one cycle, so each access gets a single ack
    assign req      = cyc & stb & ~ack;
    assign ctrl_wr  = req & we & (adr == ADDR_CTRL);
    assign rd_right = req & ~we & (adr == ADDR_RIGHT);

    ////////////////////////////////////////
    // Read selection
    ////////////////////////////////////////

    always_comb
    begin
        rd_val = '0;
        case (adr)
            ADDR_CTRL:
                rd_val[0] = enable;         // Clear bit reads back as 0
            ADDR_STATUS:
            begin
                rd_val[2:0] = level;
                rd_val[4]   = empty;
                rd_val[5]   = full;
                rd_val[6]   = overrun;
            end
            ADDR_LEFT:
                if (!empty) rd_val[15:0] = head.lft;
            ADDR_RIGHT:
                if (!empty) rd_val[15:0] = head.rgt;
            default:
                rd_val = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (req)
            dat_r <= rd_val;                // Captured with ack rising
    end

    ////////////////////////////////////////
    // Handshake and control bits
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ack     <= 1'b0;
            enable  <= 1'b0;
            overrun <= 1'b0;
            pop     <= 1'b0;
        end
        else
        begin
            ack <= req;
            pop <= rd_right & ~empty;       // FIFO advances at the end of ack
            if (ctrl_wr)
                enable <= dat_w[0];
            // A drop in the same cycle as the clear keeps the flag set
            if (drop)
                overrun <= 1'b1;
            else if (ctrl_wr && dat_w[1])
                overrun <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* i2si/i2si_deserializer.sv */
`default_nettype none

module i2si_deserializer
(
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  sck,       // Bit clock from the external master
    input  wire                  ws,        // Low for left, high for right
    input  wire                  sd,        // Serial data, changes on sck fall
    input  wire                  enable,    // Arms the receiver, clearing drops to idle
    output i2si_pkg::i2s_frame_t frame,     // Last complete stereo frame
    output logic                 xfc        // One cycle pulse per completed frame
);

    import i2si_pkg::*;

    logic [2:0] sck_sync;                   // Two sync stages plus one for edge detect
    logic [1:0] ws_sync;
    logic [1:0] sd_sync;
    logic       sck_rise;                   // Registered rising edge of the bit clock
    logic       ws_prev;                    // ws seen at the previous sck rise
    logic       ws_fall;
    logic       frame_done;
    rx_state_t  state;
    sample_t    lft_sr;                     // Left shift register
    sample_t    rgt_sr;                     // Right shift register

    ////////////////////////////////////////
    // Pin synchronizers
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sck_sync <= '0;
            ws_sync  <= '0;
            sd_sync  <= '0;
            sck_rise <= 1'b0;
        end
        else
        begin
            sck_sync <= {sck_sync[1:0], sck};
            ws_sync  <= {ws_sync[0], ws};
            sd_sync  <= {sd_sync[0], sd};
            sck_rise <= sck_sync[1] & ~sck_sync[2]; // Edge seen one flop after sync
        end
    end

    // ws and sd are stable for at least 3 clk around the rise, so the extra
    // detect stage on sck does not need matching delay on them
    assign ws_fall    = ws_prev & ~ws_sync[1];
    assign frame_done = sck_rise & ws_fall & (state == RX_ACTIVE);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            ws_prev <= 1'b0;
        else if (sck_rise)
            ws_prev <= ws_sync[1];          // Channel of the next bit (one bit delay)
    end

    ////////////////////////////////////////
    // Idle, armed, active sequence
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state <= RX_IDLE;
        else if (!enable)
            state <= RX_IDLE;               // Partial frame is abandoned
        else
        begin
            case (state)
                RX_IDLE:   state <= RX_ARMED;
                RX_ARMED:  if (sck_rise && ws_fall) state <= RX_ACTIVE; // Sync only
                RX_ACTIVE: state <= RX_ACTIVE;
                default:   state <= RX_IDLE;
            endcase
        end
    end

    // Shift on every rise, ws_prev picks the channel
    always_ff @(posedge clk)
    begin
        if (sck_rise)
        begin
            if (ws_prev)
                rgt_sr <= {rgt_sr[14:0], sd_sync[1]};
            else
                lft_sr <= {lft_sr[14:0], sd_sync[1]};
        end
    end

    // Bit taken at the ws fall is the right LSB, so it is merged in here
    always_ff @(posedge clk)
    begin
        if (frame_done)
        begin
            frame.lft <= lft_sr;
            frame.rgt <= {rgt_sr[14:0], sd_sync[1]};
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            xfc <= 1'b0;
        else
            xfc <= frame_done;              // Lines up with the new frame value
    end

endmodule

`default_nettype wire

/* i2si/i2si_frame_fifo.sv */
`default_nettype none

module i2si_frame_fifo
#(
    parameter int unsigned DEPTH = i2si_pkg::FIFO_DEPTH   // Power of two
)
(
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         push,   // Frame strobe from the deserializer
    input  wire  i2si_pkg::i2s_frame_t  din,
    input  wire                         pop,    // Ignored while empty
    output i2si_pkg::i2s_frame_t        head,   // Oldest stored frame
    output i2si_pkg::fifo_level_t       level,
    output logic                        empty,
    output logic                        full,
    output logic                        drop    // Push refused, FIFO was full
);

    import i2si_pkg::*;

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    i2s_frame_t       mem [DEPTH];          // Frame storage
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    fifo_level_t      count;                // Occupancy
    logic             do_push;
    logic             do_pop;

    assign full    = (count == fifo_level_t'(DEPTH));
    assign empty   = (count == '0);
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;
    assign head    = mem[rd_ptr];
    assign level   = count;

    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr] <= din;
    end

    ////////////////////////////////////////
    // Pointers and occupancy
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            drop   <= 1'b0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Both or neither, level holds
            endcase
            drop <= push & full;            // Stored frames stay untouched
        end
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+tests
common/i2si_pkg.sv
i2si/i2si_deserializer.sv
i2si/i2si_frame_fifo.sv
hw/i2si_wb_regs.sv
hw/i2si_top.sv
tests/tb_i2si_top.sv

/* tests/i2si_tb_tasks.svh */
`ifndef I2SI_TB_TASKS_SVH
`define I2SI_TB_TASKS_SVH

////////////////////////////////////////
// I2S master model
////////////////////////////////////////

// One bit slot with sck low for 4 clk then high for 4 clk (8 clk period)
task automatic drive_slot(input logic bit_v, input logic ws_v);
    sck = 1'b0;                             // Data and ws change on the fall
    sd  = bit_v;
    ws  = ws_v;
    repeat (4) @(negedge clk);
    sck = 1'b1;                             // DUT samples on this rise
    repeat (4) @(negedge clk);
endtask

// Slot i carries the left word MSB first and then the right word
// ws leads the data by one slot
task automatic send_slots(input sample_t lft, input sample_t rgt, input int n_slots);
    for (int i = 0; i < n_slots; i++)
    begin
        drive_slot((i < 16) ? lft[15 - i] : rgt[31 - i], ((i + 1) % 32) >= 16);
    end
endtask

// Whole frames of random words that also go to the reference model
task automatic send_frames(input int n);
    sample_t lft;
    sample_t rgt;
    for (int f = 0; f < n; f++)
    begin
        lft = sample_t'($random(seed));
        rgt = sample_t'($random(seed));
        send_slots(lft, rgt, 32);
        model_frame_end(lft, rgt);
    end
    repeat (8) @(negedge clk);              // Sync, edge detect, xfc and level update
endtask

// Leading part of a frame that never reaches the model
task automatic send_partial(input int n_slots);
    sample_t lft;
    sample_t rgt;
    lft = sample_t'($random(seed));
    rgt = sample_t'($random(seed));
    send_slots(lft, rgt, n_slots);
endtask

////////////////////////////////////////
// Wishbone classic master
////////////////////////////////////////

task automatic wb_access(input logic write, input wb_addr_t adr, input wb_data_t wdata,
                         output wb_data_t rdata);
    int waited;
    waited = 0;
    rdata  = '0;
    @(negedge clk);
    wb_cyc   = 1'b1;                        // Held until ack is seen
    wb_stb   = 1'b1;
    wb_we    = write;
    wb_adr   = adr;
    wb_dat_w = wdata;
    @(negedge clk);
    while (!wb_ack && waited < TIMEOUT_CYCLES)
    begin
        @(negedge clk);
        waited++;
    end
    if (wb_ack)
        rdata = wb_dat_r;                   // Valid while ack is high
    else
    begin
        $display("Wishbone access to address %0d got no ack within %0d cycles",
                 adr, TIMEOUT_CYCLES);
        errors++;
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
endtask

task automatic wb_write(input wb_addr_t adr, input wb_data_t data);
    wb_data_t unused;
    wb_access(1'b1, adr, data, unused);
endtask

task automatic wb_read(input wb_addr_t adr, output wb_data_t data);
    wb_access(1'b0, adr, '0, data);
endtask

`endif

/* tests/tb_i2si_top.sv */
`default_nettype none

module tb_i2si_top;

    import i2si_pkg::*;

    localparam int TIMEOUT_CYCLES = 50;     // Per Wishbone access
    localparam int ST_IDLE   = 0;           // Model of RX_IDLE
    localparam int ST_ARMED  = 1;           // Model of RX_ARMED
    localparam int ST_ACTIVE = 2;           // Model of RX_ACTIVE

    logic       clk;
    logic       rst_n;
    logic       sck;
    logic       ws;
    logic       sd;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    wb_addr_t   wb_adr;
    wb_data_t   wb_dat_w;
    wb_data_t   wb_dat_r;
    logic       wb_ack;

    integer     seed;                       // Shared by all $random calls
    int         errors;
    int         test_start;                 // Error count when the test began
    int         tests_ok;
    int         tests_bad;
    i2s_frame_t exp_q[$];                   // Frames the FIFO should hold
    logic       exp_overrun;
    int         model_state;

    i2si_top u_i2si_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .sck      (sck),
        .ws       (ws),
        .sd       (sd),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    `include "i2si_tb_tasks.svh"

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Classic handshake, ack is a single cycle pulse
    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) wb_ack |=> !wb_ack)
        else
        begin
            $display("Wishbone ack stayed high for two cycles at time %0t", $time);
            errors++;
        end

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    task automatic model_frame_end(input sample_t lft, input sample_t rgt);
        case (model_state)
            ST_ARMED:  model_state = ST_ACTIVE; // First ws fall only syncs
            ST_ACTIVE:
                if (exp_q.size() < FIFO_DEPTH)
                    exp_q.push_back({lft, rgt});
                else
                    exp_overrun = 1'b1;     // Full, frame dropped
            default:   ;
        endcase
    endtask

    function automatic wb_data_t expected_status();
        wb_data_t s;
        s      = '0;
        s[2:0] = fifo_level_t'(exp_q.size());
        s[4]   = (exp_q.size() == 0);
        s[5]   = (exp_q.size() == FIFO_DEPTH);
        s[6]   = exp_overrun;
        return s;
    endfunction

    task automatic write_ctrl(input wb_data_t data);
        wb_write(ADDR_CTRL, data);
        if (!data[0])
            model_state = ST_IDLE;          // Partial frame lost
        else if (model_state == ST_IDLE)
            model_state = ST_ARMED;
        if (data[1])
            exp_overrun = 1'b0;
    endtask

    ////////////////////////////////////////
    // Checks and result lines
    ////////////////////////////////////////

    task automatic check_value(input string name, input wb_data_t exp, input wb_data_t act);
        assert (act === exp)
        else
        begin
            $display("CHECK FAILED %s: expected 0x%08h, actual 0x%08h", name, exp, act);
            errors++;
        end
    endtask

    task automatic read_check(input string name, input wb_addr_t adr, input wb_data_t exp);
        wb_data_t act;
        wb_read(adr, act);
        check_value(name, exp, act);
    endtask

    // Drain the model queue, RIGHT read pops so STATUS drops by one each time
    task automatic read_back_frames(input string name);
        i2s_frame_t f;
        while (exp_q.size() > 0)
        begin
            f = exp_q.pop_front();
            read_check({name, " left"}, ADDR_LEFT, {16'h0, f.lft});
            read_check({name, " right"}, ADDR_RIGHT, {16'h0, f.rgt});
            read_check({name, " status"}, ADDR_STATUS, expected_status());
        end
    endtask

    task automatic end_test(input string name);
        if (errors == test_start)
        begin
            tests_ok++;
            $display("test %s: ok", name);
        end
        else
        begin
            tests_bad++;
            $display("test %s: %0d error(s)", name, errors - test_start);
        end
        test_start = errors;
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial
    begin
        seed        = 84663;
        errors      = 0;
        test_start  = 0;
        tests_ok    = 0;
        tests_bad   = 0;
        exp_overrun = 1'b0;
        model_state = ST_IDLE;
        rst_n       = 1'b0;
        sck         = 1'b0;
        ws          = 1'b0;
        sd          = 1'b0;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_dat_w    = '0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        read_check("reset ctrl", ADDR_CTRL, 32'h0);
        read_check("reset status", ADDR_STATUS, expected_status());
        read_check("reset left", ADDR_LEFT, 32'h0);
        read_check("reset right", ADDR_RIGHT, 32'h0);
        end_test("reset values");

        send_frames(3);                     // Receiver idle, nothing captured
        read_check("disabled status", ADDR_STATUS, expected_status());
        end_test("disabled");

        write_ctrl(32'h1);
        send_frames(4);                     // First one only arms
        read_check("enabled status", ADDR_STATUS, expected_status());
        read_back_frames("enabled");
        end_test("enabled capture");

        send_frames(FIFO_DEPTH + 2);
        read_check("overflow status", ADDR_STATUS, expected_status());
        read_back_frames("overflow");
        write_ctrl(32'h3);                  // Keep enable, clear overrun
        read_check("overflow ctrl", ADDR_CTRL, 32'h1);
        read_check("overflow cleared", ADDR_STATUS, expected_status());
        end_test("overflow");

        send_frames(1);
        send_partial(10);                   // Stop inside the left half
        write_ctrl(32'h0);
        write_ctrl(32'h1);
        send_frames(3);
        read_check("rearm status", ADDR_STATUS, expected_status());
        read_back_frames("rearm");
        end_test("rearm");

        read_check("empty right", ADDR_RIGHT, 32'h0);
        read_check("empty status", ADDR_STATUS, expected_status());
        end_test("empty pop");

        $display("tests ok: %0d, tests with errors: %0d", tests_ok, tests_bad);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire
